// File: dl1c_pkg.sv
`default_nettype none

package dl1c_pkg;

  // Cache geometry
  localparam int num_ways = 2;
  localparam int num_sets = 16;
  localparam int set_width = $clog2(num_sets);

  // Lines are 32 bytes, matching the level-two line size
  localparam int line_bytes = 32;
  localparam int line_width = line_bytes * 8;
  localparam int words_per_line = line_bytes / 4;
  localparam int offs_width = $clog2(words_per_line);

  // Word address is 30 bits, whatever is left above set and offset is tag
  localparam int tag_width = 30 - set_width - offs_width;

  // Data and address vectors
  typedef logic [31:0] word_t;
  typedef logic [tag_width+set_width+offs_width-1:0] word_addr_t;
  typedef logic [tag_width+set_width-1:0] line_addr_t;
  typedef logic [tag_width-1:0] tag_t;
  typedef logic [set_width-1:0] set_idx_t;
  typedef logic [offs_width-1:0] word_offs_t;

  // Byte enables of one word and of a whole line
  typedef logic [3:0] byte_en_t;
  typedef logic [line_width-1:0] line_t;
  typedef logic [line_bytes-1:0] line_be_t;

  typedef logic [$clog2(num_ways)-1:0] way_t;

  // Level-two opcodes, same encoding the level-two cache decodes
  typedef enum logic [2:0] {
    l2_opc_read  = 3'b000,
    l2_opc_write = 3'b001
  } l2_opcode_t;

endpackage

`default_nettype wire

// File: dl1c_write_merge.sv
`default_nettype none
`timescale 1ns/1ns

module dl1c_write_merge (
  input  wire dl1c_pkg::line_t      line_in,
  input  wire dl1c_pkg::word_offs_t offs,
  input  wire dl1c_pkg::byte_en_t   we,
  input  wire dl1c_pkg::word_t      wdata,
  output dl1c_pkg::line_t           merged_line,
  output dl1c_pkg::line_be_t        merged_be
);

  // Byte lanes of the addressed word, bytes without an enable keep the cached value
  always_comb begin
    merged_line = line_in;
    for (int b = 0; b < 4; b++) begin
      if (we[b]) begin
        merged_line[offs * 32 + b * 8 +: 8] = wdata[b * 8 +: 8];
      end
    end
  end

  // Line mask for the level-two write, zero outside the addressed word
  always_comb begin
    merged_be = '0;
    merged_be[offs * 4 +: 4] = we;
  end

endmodule

`default_nettype wire

// File: dl1c_line_ram.sv
`default_nettype none
`timescale 1ns/1ns

module dl1c_line_ram (
  input  wire logic               clkrst_mem_clk,
  input  wire dl1c_pkg::set_idx_t rd_set,
  input  wire logic               we,
  input  wire dl1c_pkg::way_t     way,
  input  wire dl1c_pkg::line_t    wline,
  output dl1c_pkg::line_t         rd_line_0,
  output dl1c_pkg::line_t         rd_line_1
);

  dl1c_pkg::line_t mem [dl1c_pkg::num_ways][dl1c_pkg::num_sets];

  // Writes share the read set
  always_ff @(posedge clkrst_mem_clk) begin
    if (we) begin
      mem[way][rd_set] <= wline;
    end
  end

  // Write-first read, so the lookup after a refill sees the new line
  always_ff @(posedge clkrst_mem_clk) begin
    if (we && (way == 1'b0)) begin
      rd_line_0 <= wline;
    end else begin
      rd_line_0 <= mem[0][rd_set];
    end

    if (we && (way == 1'b1)) begin
      rd_line_1 <= wline;
    end else begin
      rd_line_1 <= mem[1][rd_set];
    end
  end

endmodule

`default_nettype wire

// File: dl1c_tag_store.sv
`default_nettype none
`timescale 1ns/1ns

module dl1c_tag_store (
  input  wire logic                 clkrst_mem_clk,
  input  wire logic                 clkrst_mem_rst_n,
  input  wire dl1c_pkg::word_addr_t cur_addr,
  input  wire logic                 tag_fill,
  input  wire logic                 tag_touch,
  output logic                      hit,
  output dl1c_pkg::way_t            hit_way,
  output dl1c_pkg::way_t            victim_way
);

  dl1c_pkg::tag_t                  cur_tag;
  dl1c_pkg::set_idx_t              set_idx;
  logic [dl1c_pkg::num_ways-1:0]   way_hit;

  // Tags per way and set
  dl1c_pkg::tag_t                  tag_mem [dl1c_pkg::num_ways][dl1c_pkg::num_sets];
  logic [dl1c_pkg::num_sets-1:0]   valid [dl1c_pkg::num_ways];

  // One bit per set, names the way to replace next
  logic [dl1c_pkg::num_sets-1:0]   evict;

  assign cur_tag = cur_addr[dl1c_pkg::offs_width + dl1c_pkg::set_width +: dl1c_pkg::tag_width];
  assign set_idx = cur_addr[dl1c_pkg::offs_width +: dl1c_pkg::set_width];

  always_comb begin
    for (int w = 0; w < dl1c_pkg::num_ways; w++) begin
      way_hit[w] = valid[w][set_idx] && (tag_mem[w][set_idx] == cur_tag);
    end
  end

  assign hit = |way_hit;

  // At most one way matches, so way 1 hitting gives the index
  assign hit_way    = way_hit[1];
  assign victim_way = evict[set_idx];

  always_ff @(posedge clkrst_mem_clk) begin
    if (tag_fill) begin
      tag_mem[victim_way][set_idx] <= cur_tag;
    end
  end

  always_ff @(posedge clkrst_mem_clk or negedge clkrst_mem_rst_n) begin
    if (!clkrst_mem_rst_n) begin
      for (int w = 0; w < dl1c_pkg::num_ways; w++) begin
        valid[w] <= '0;
      end
      evict <= '0;
    end else begin
      if (tag_fill) begin
        valid[victim_way][set_idx] <= 1'b1;
      end
      // On a hit the other way becomes the next victim
      if (tag_touch) begin
        evict[set_idx] <= ~hit_way;
      end
    end
  end

endmodule

`default_nettype wire

// File: dl1c_ctrl.sv
`default_nettype none
`timescale 1ns/1ns

module dl1c_ctrl (
  input  wire logic                 clkrst_mem_clk,
  input  wire logic                 clkrst_mem_rst_n,

  // CPU request side
  input  wire logic                 req_valid,
  input  wire dl1c_pkg::word_addr_t req_addr,
  input  wire dl1c_pkg::byte_en_t   req_we,
  input  wire dl1c_pkg::word_t      req_wdata,

  // Lookup results and line data
  input  wire logic                 hit,
  input  wire dl1c_pkg::way_t       hit_way,
  input  wire dl1c_pkg::way_t       victim_way,
  input  wire dl1c_pkg::line_t      rd_line,
  input  wire dl1c_pkg::line_t      merged_line,
  input  wire dl1c_pkg::line_be_t   merged_be,

  // Level-two response side
  input  wire dl1c_pkg::line_t      l2_rdata,
  input  wire logic                 l2_rvalid,
  input  wire logic                 l2_stall,

  output logic                      req_ready,
  output logic                      rsp_valid,
  output dl1c_pkg::word_t           rsp_data,

  // Registered request, shared with tag store and merge
  output dl1c_pkg::word_addr_t      cur_addr,
  output dl1c_pkg::byte_en_t        cur_we,
  output dl1c_pkg::word_t           cur_wdata,

  // Line RAM and tag store control
  output dl1c_pkg::set_idx_t        ram_rd_set,
  output logic                      ram_we,
  output dl1c_pkg::way_t            ram_way,
  output dl1c_pkg::line_t           ram_wline,
  output logic                      tag_fill,
  output logic                      tag_touch,

  // Level-two request register
  output logic                      l2_valid,
  output dl1c_pkg::l2_opcode_t      l2_opcode,
  output dl1c_pkg::line_addr_t      l2_addr,
  output dl1c_pkg::line_t           l2_wdata,
  output dl1c_pkg::line_be_t        l2_wbe
);

  typedef enum logic [2:0] {
    st_idle,
    st_lookup,
    st_fill_req,
    st_fill_wait,
    st_wt
  } state_t;

  state_t               state;
  state_t               state_nxt;
  logic                 is_read;
  logic                 l2_issue;
  logic                 wr_done;
  dl1c_pkg::set_idx_t   cur_set;
  dl1c_pkg::word_offs_t cur_offs;

  assign cur_set  = cur_addr[dl1c_pkg::offs_width +: dl1c_pkg::set_width];
  assign cur_offs = cur_addr[dl1c_pkg::offs_width-1:0];
  assign is_read  = (cur_we == '0);

  // One request in flight, so accept only when idle
  assign req_ready = (state == st_idle);

  // Idle reads ahead at the incoming set so a hit needs no extra cycle
  assign ram_rd_set = (state == st_idle) ?
                      req_addr[dl1c_pkg::offs_width +: dl1c_pkg::set_width] : cur_set;

  assign rsp_data = rd_line[cur_offs * 32 +: 32];

  always_comb begin
    state_nxt = state;
    rsp_valid = wr_done;
    tag_touch = 1'b0;
    tag_fill  = 1'b0;
    ram_we    = 1'b0;
    ram_way   = hit_way;
    ram_wline = merged_line;
    l2_issue  = 1'b0;

    case (state)
      st_idle: begin
        if (req_valid) begin
          state_nxt = st_lookup;
        end
      end

      st_lookup: begin
        // Read hits never touch the level-two side
        if (hit && is_read) begin
          rsp_valid = 1'b1;
          tag_touch = 1'b1;
          state_nxt = st_idle;
        end else if (!l2_stall) begin
          l2_issue = 1'b1;
          if (hit) begin
            tag_touch = 1'b1;
            state_nxt = st_wt;
          end else begin
            state_nxt = st_fill_req;
          end
        end
      end

      // Read request is on the bus until the level-two cache takes it
      st_fill_req: begin
        if (!l2_stall) begin
          state_nxt = st_fill_wait;
        end
      end

      st_fill_wait: begin
        if (l2_rvalid && !l2_stall) begin
          ram_we    = 1'b1;
          ram_way   = victim_way;
          ram_wline = l2_rdata;
          tag_fill  = 1'b1;
          state_nxt = st_lookup;
        end
      end

      // Cached copy is updated on the same edge the write is accepted
      st_wt: begin
        if (!l2_stall) begin
          ram_we    = 1'b1;
          state_nxt = st_idle;
        end
      end

      default: state_nxt = st_idle;
    endcase
  end

  always_ff @(posedge clkrst_mem_clk or negedge clkrst_mem_rst_n) begin
    if (!clkrst_mem_rst_n) begin
      state    <= st_idle;
      wr_done  <= 1'b0;
      l2_valid <= 1'b0;
    end else begin
      state   <= state_nxt;
      wr_done <= (state == st_wt) && !l2_stall;
      // Valid drops on the accepting edge unless a new request is issued
      if (!l2_stall) begin
        l2_valid <= l2_issue;
      end
    end
  end

  // Request payload
  always_ff @(posedge clkrst_mem_clk) begin
    if (req_valid && req_ready) begin
      cur_addr  <= req_addr;
      cur_we    <= req_we;
      cur_wdata <= req_wdata;
    end
  end

  // Level-two payload, a hit here is always a write-through
  always_ff @(posedge clkrst_mem_clk) begin
    if (l2_issue && !l2_stall) begin
      l2_opcode <= hit ? dl1c_pkg::l2_opc_write : dl1c_pkg::l2_opc_read;
      l2_addr   <= cur_addr[dl1c_pkg::offs_width +: dl1c_pkg::set_width + dl1c_pkg::tag_width];
      l2_wdata  <= merged_line;
      l2_wbe    <= hit ? merged_be : '0;
    end
  end

endmodule

`default_nettype wire

// File: dl1c_top.sv
`default_nettype none
`timescale 1ns/1ns

module dl1c_top (
  input  wire logic                 clkrst_mem_clk,
  input  wire logic                 clkrst_mem_rst_n,

  // CPU port
  input  wire logic                 req_valid,
  input  wire dl1c_pkg::word_addr_t req_addr,
  input  wire dl1c_pkg::byte_en_t   req_we,
  input  wire dl1c_pkg::word_t      req_wdata,
  output logic                      req_ready,
  output logic                      rsp_valid,
  output dl1c_pkg::word_t           rsp_data,

  // Level-two port
  output logic                      l2_valid,
  output dl1c_pkg::l2_opcode_t      l2_opcode,
  output dl1c_pkg::line_addr_t      l2_addr,
  output dl1c_pkg::line_t           l2_wdata,
  output dl1c_pkg::line_be_t        l2_wbe,
  input  wire dl1c_pkg::line_t      l2_rdata,
  input  wire logic                 l2_rvalid,
  input  wire logic                 l2_stall
);

  dl1c_pkg::word_addr_t cur_addr;
  dl1c_pkg::byte_en_t   cur_we;
  dl1c_pkg::word_t      cur_wdata;

  dl1c_pkg::set_idx_t   ram_rd_set;
  logic                 ram_we;
  dl1c_pkg::way_t       ram_way;
  dl1c_pkg::line_t      ram_wline;
  dl1c_pkg::line_t      rd_line_0;
  dl1c_pkg::line_t      rd_line_1;

  logic                 tag_fill;
  logic                 tag_touch;
  logic                 hit;
  dl1c_pkg::way_t       hit_way;
  dl1c_pkg::way_t       victim_way;

  dl1c_pkg::line_t      merged_line;
  dl1c_pkg::line_be_t   merged_be;

  // Line of the way that hit, feeds both the response and the merge
  wire dl1c_pkg::line_t sel_line = hit_way ? rd_line_1 : rd_line_0;

  dl1c_ctrl u_ctrl (
    .clkrst_mem_clk   (clkrst_mem_clk),
    .clkrst_mem_rst_n (clkrst_mem_rst_n),
    .req_valid        (req_valid),
    .req_addr         (req_addr),
    .req_we           (req_we),
    .req_wdata        (req_wdata),
    .hit              (hit),
    .hit_way          (hit_way),
    .victim_way       (victim_way),
    .rd_line          (sel_line),
    .merged_line      (merged_line),
    .merged_be        (merged_be),
    .l2_rdata         (l2_rdata),
    .l2_rvalid        (l2_rvalid),
    .l2_stall         (l2_stall),
    .req_ready        (req_ready),
    .rsp_valid        (rsp_valid),
    .rsp_data         (rsp_data),
    .cur_addr         (cur_addr),
    .cur_we           (cur_we),
    .cur_wdata        (cur_wdata),
    .ram_rd_set       (ram_rd_set),
    .ram_we           (ram_we),
    .ram_way          (ram_way),
    .ram_wline        (ram_wline),
    .tag_fill         (tag_fill),
    .tag_touch        (tag_touch),
    .l2_valid         (l2_valid),
    .l2_opcode        (l2_opcode),
    .l2_addr          (l2_addr),
    .l2_wdata         (l2_wdata),
    .l2_wbe           (l2_wbe)
  );

  dl1c_tag_store u_tags (
    .clkrst_mem_clk   (clkrst_mem_clk),
    .clkrst_mem_rst_n (clkrst_mem_rst_n),
    .cur_addr         (cur_addr),
    .tag_fill         (tag_fill),
    .tag_touch        (tag_touch),
    .hit              (hit),
    .hit_way          (hit_way),
    .victim_way       (victim_way)
  );

  dl1c_line_ram u_lines (
    .clkrst_mem_clk (clkrst_mem_clk),
    .rd_set         (ram_rd_set),
    .we             (ram_we),
    .way            (ram_way),
    .wline          (ram_wline),
    .rd_line_0      (rd_line_0),
    .rd_line_1      (rd_line_1)
  );

  dl1c_write_merge u_merge (
    .line_in     (sel_line),
    .offs        (cur_addr[dl1c_pkg::offs_width-1:0]),
    .we          (cur_we),
    .wdata       (cur_wdata),
    .merged_line (merged_line),
    .merged_be   (merged_be)
  );

endmodule

`default_nettype wire

// File: tb_l2_model.sv
`default_nettype none
`timescale 1ns/1ns

module tb_l2_model (
  input  wire logic                 clkrst_mem_clk,
  input  wire logic                 stall_en,
  input  wire logic                 l2_valid,
  input  wire dl1c_pkg::l2_opcode_t l2_opcode,
  input  wire dl1c_pkg::line_addr_t l2_addr,
  input  wire dl1c_pkg::line_t      l2_wdata,
  input  wire dl1c_pkg::line_be_t   l2_wbe,
  output dl1c_pkg::line_t           l2_rdata,
  output logic                      l2_rvalid,
  output logic                      l2_stall,
  output integer                    read_count,
  output integer                    write_count,
  output dl1c_pkg::line_t           last_wline,
  output dl1c_pkg::line_be_t        last_wbe
);

  localparam int read_latency = 3;

  // Indexed by the low 8 bits of the line address
  dl1c_pkg::line_t      mem [256];
  integer               seed;
  integer               wait_cnt;
  logic                 take;
  logic                 rsp_taken;
  logic                 pending;
  logic [7:0]           rd_idx;
  dl1c_pkg::l2_opcode_t op_q;
  dl1c_pkg::line_addr_t addr_q;
  dl1c_pkg::line_t      wdata_q;
  dl1c_pkg::line_be_t   wbe_q;

  initial begin
    seed = 69;
    for (int i = 0; i < 256; i++) begin
      for (int k = 0; k < dl1c_pkg::line_bytes; k++) begin
        mem[i][k*8 +: 8] = 8'(i + k);
      end
    end
    l2_rdata    = '0;
    l2_rvalid   = 1'b0;
    l2_stall    = 1'b0;
    read_count  = 0;
    write_count = 0;
    last_wline  = '0;
    last_wbe    = '0;
    pending     = 1'b0;
    wait_cnt    = 0;
    rd_idx      = '0;
    forever begin
      // Handshake values at the falling edge are what the cache sees at the next rising edge
      @(negedge clkrst_mem_clk);
      take      = (l2_valid === 1'b1) && !l2_stall;
      rsp_taken = l2_rvalid && !l2_stall;
      op_q      = l2_opcode;
      addr_q    = l2_addr;
      wdata_q   = l2_wdata;
      wbe_q     = l2_wbe;
      // Log the request ahead of the edge that accepts it
      if (take && (op_q == dl1c_pkg::l2_opc_read)) begin
        read_count = read_count + 1;
        rd_idx     = addr_q[7:0];
        pending    = 1'b1;
        wait_cnt   = read_latency;
      end else if (take && (op_q == dl1c_pkg::l2_opc_write)) begin
        write_count = write_count + 1;
        last_wline  = wdata_q;
        last_wbe    = wbe_q;
        for (int k = 0; k < dl1c_pkg::line_bytes; k++) begin
          if (wbe_q[k]) begin
            mem[addr_q[7:0]][k*8 +: 8] = wdata_q[k*8 +: 8];
          end
        end
      end
      @(posedge clkrst_mem_clk);
      #1;
      if (rsp_taken) begin
        l2_rvalid = 1'b0;
      end
      if (pending) begin
        if (wait_cnt == 0) begin
          l2_rdata  = mem[rd_idx];
          l2_rvalid = 1'b1;
          pending   = 1'b0;
        end else begin
          wait_cnt = wait_cnt - 1;
        end
      end
      l2_stall = stall_en ? (($random(seed) & 7) < 3) : 1'b0;
    end
  end

endmodule

`default_nettype wire

// File: tb_dl1c.sv
`default_nettype none
`timescale 1ns/1ns

module tb_dl1c;

  localparam int rsp_timeout = 200;

  logic                 clkrst_mem_clk;
  logic                 clkrst_mem_rst_n;
  logic                 req_valid;
  dl1c_pkg::word_addr_t req_addr;
  dl1c_pkg::byte_en_t   req_we;
  dl1c_pkg::word_t      req_wdata;
  logic                 req_ready;
  logic                 rsp_valid;
  dl1c_pkg::word_t      rsp_data;
  logic                 l2_valid;
  dl1c_pkg::l2_opcode_t l2_opcode;
  dl1c_pkg::line_addr_t l2_addr;
  dl1c_pkg::line_t      l2_wdata;
  dl1c_pkg::line_be_t   l2_wbe;
  dl1c_pkg::line_t      l2_rdata;
  logic                 l2_rvalid;
  logic                 l2_stall;
  logic                 stall_en;
  integer               read_count;
  integer               write_count;
  dl1c_pkg::line_t      last_wline;
  dl1c_pkg::line_be_t   last_wbe;

  // Reference words for tags 0 to 15, indexed by word address bits 10 down to 0
  dl1c_pkg::word_t      ref_mem [2048];
  integer               errors;
  integer               timeouts;
  integer               seed;

  dl1c_top dut0 (
    .clkrst_mem_clk (clkrst_mem_clk), .clkrst_mem_rst_n (clkrst_mem_rst_n),
    .req_valid (req_valid), .req_addr (req_addr), .req_we (req_we), .req_wdata (req_wdata),
    .req_ready (req_ready), .rsp_valid (rsp_valid), .rsp_data (rsp_data),
    .l2_valid (l2_valid), .l2_opcode (l2_opcode), .l2_addr (l2_addr),
    .l2_wdata (l2_wdata), .l2_wbe (l2_wbe),
    .l2_rdata (l2_rdata), .l2_rvalid (l2_rvalid), .l2_stall (l2_stall)
  );

  tb_l2_model l2_0 (
    .clkrst_mem_clk (clkrst_mem_clk), .stall_en (stall_en),
    .l2_valid (l2_valid), .l2_opcode (l2_opcode), .l2_addr (l2_addr),
    .l2_wdata (l2_wdata), .l2_wbe (l2_wbe),
    .l2_rdata (l2_rdata), .l2_rvalid (l2_rvalid), .l2_stall (l2_stall),
    .read_count (read_count), .write_count (write_count),
    .last_wline (last_wline), .last_wbe (last_wbe)
  );

  initial begin
    clkrst_mem_clk = 1'b0;
    forever #2 clkrst_mem_clk = ~clkrst_mem_clk;
  end

  // Byte k of line L holds the low 8 bits of L plus k
  function automatic dl1c_pkg::word_t preload_word(input logic [10:0] idx);
    dl1c_pkg::word_t w;
    for (int i = 0; i < 4; i++) begin
      w[i*8 +: 8] = idx[10:3] + 8'(idx[2:0] * 4 + i);
    end
    return w;
  endfunction

  function automatic dl1c_pkg::line_t ref_line(input logic [7:0] lidx);
    dl1c_pkg::line_t ln;
    for (int w = 0; w < dl1c_pkg::words_per_line; w++) begin
      ln[w*32 +: 32] = ref_mem[{lidx, 3'(w)}];
    end
    return ln;
  endfunction

  function automatic dl1c_pkg::word_addr_t make_addr(input dl1c_pkg::tag_t tag,
      input dl1c_pkg::set_idx_t set, input dl1c_pkg::word_offs_t offs);
    return {tag, set, offs};
  endfunction

  task automatic check_word(input string name, input dl1c_pkg::word_t exp,
      input dl1c_pkg::word_t act);
    if (act !== exp) begin
      errors++;
      $display("FAILED %s: expected %h, actual %h", name, exp, act);
    end
  endtask

  task automatic check_count(input string name, input integer exp, input integer act);
    if (act !== exp) begin
      errors++;
      $display("FAILED %s: expected %0d, actual %0d", name, exp, act);
    end
  endtask

  task automatic check_line(input string name, input dl1c_pkg::line_t exp,
      input dl1c_pkg::line_t act);
    if (act !== exp) begin
      errors++;
      $display("FAILED %s: expected %h, actual %h", name, exp, act);
    end
  endtask

  task automatic check_be(input string name, input dl1c_pkg::line_be_t exp,
      input dl1c_pkg::line_be_t act);
    if (act !== exp) begin
      errors++;
      $display("FAILED %s: expected %h, actual %h", name, exp, act);
    end
  endtask

  // One request through the CPU handshake, returns the response word
  task automatic send_req(input string name, input dl1c_pkg::word_addr_t addr,
      input dl1c_pkg::byte_en_t we, input dl1c_pkg::word_t wdata,
      output dl1c_pkg::word_t data);
    int cnt;
    data = '0;
    if (timeouts != 0) return;
    req_valid = 1'b1;
    req_addr  = addr;
    req_we    = we;
    req_wdata = wdata;
    cnt = 0;
    while (!req_ready && cnt < rsp_timeout) begin
      @(posedge clkrst_mem_clk);
      #1;
      cnt++;
    end
    if (!req_ready) begin
      timeouts++;
      req_valid = 1'b0;
      $display("%s: the cache never became ready for a request", name);
      return;
    end
    @(posedge clkrst_mem_clk);
    #1;
    req_valid = 1'b0;
    cnt = 0;
    while (!rsp_valid && cnt < rsp_timeout) begin
      @(posedge clkrst_mem_clk);
      #1;
      cnt++;
    end
    if (!rsp_valid) begin
      timeouts++;
      $display("%s: the cache gave no response", name);
      return;
    end
    data = rsp_data;
  endtask

  task automatic do_read(input string name, input dl1c_pkg::word_addr_t addr);
    dl1c_pkg::word_t data;
    send_req(name, addr, 4'b0000, '0, data);
    if (timeouts == 0) begin
      check_word(name, ref_mem[addr[10:0]], data);
    end
  endtask

  task automatic do_write(input string name, input dl1c_pkg::word_addr_t addr,
      input dl1c_pkg::byte_en_t we, input dl1c_pkg::word_t wdata);
    dl1c_pkg::word_t data;
    send_req(name, addr, we, wdata, data);
    for (int b = 0; b < 4; b++) begin
      if (we[b]) begin
        ref_mem[addr[10:0]][b*8 +: 8] = wdata[b*8 +: 8];
      end
    end
  endtask

  // Read and check how many line fetches it caused
  task automatic read_and_count(input string name, input dl1c_pkg::word_addr_t addr,
      input integer fetches);
    integer rc;
    rc = read_count;
    do_read(name, addr);
    check_count({name, " reads"}, rc + fetches, read_count);
  endtask

  task automatic test_partial_write();
    dl1c_pkg::word_addr_t a;
    dl1c_pkg::line_be_t   exp_be;
    integer               rc;
    integer               wc;
    a = make_addr(3, 1, 5);
    rc = read_count;
    wc = write_count;
    do_write("partial_write", a, 4'b0101, 32'hc3a5_96e1);
    check_count("partial_write writes", wc + 1, write_count);
    check_count("partial_write reads", rc, read_count);
    exp_be = '0;
    exp_be[5*4 +: 4] = 4'b0101;
    check_line("partial_write line", ref_line(a[10:3]), last_wline);
    check_be("partial_write mask", exp_be, last_wbe);
    read_and_count("partial_write readback", a, 0);
  endtask

  task automatic test_write_miss();
    dl1c_pkg::word_addr_t a;
    integer               rc;
    integer               wc;
    a = make_addr(5, 2, 3);
    rc = read_count;
    wc = write_count;
    do_write("write_miss", a, 4'b1111, 32'h1234_5678);
    check_count("write_miss reads", rc + 1, read_count);
    check_count("write_miss writes", wc + 1, write_count);
    read_and_count("write_miss readback", a, 0);
  endtask

  // A, B and C share set 7
  task automatic test_replacement();
    read_and_count("replace_a_cold", make_addr(10, 7, 0), 1);
    read_and_count("replace_b_cold", make_addr(11, 7, 1), 1);
    read_and_count("replace_a_hit", make_addr(10, 7, 2), 0);
    read_and_count("replace_c_cold", make_addr(12, 7, 3), 1);
    read_and_count("replace_a_kept", make_addr(10, 7, 4), 0);
    read_and_count("replace_b_evicted", make_addr(11, 7, 5), 1);
  endtask

  task automatic test_random_stalls();
    dl1c_pkg::word_addr_t a;
    stall_en = 1'b1;
    repeat (60) begin
      a = make_addr($random(seed) & 3, $random(seed) & 3, $random(seed) & 7);
      if ($random(seed) & 1) begin
        do_write("random_write", a, $random(seed) & 15, $random(seed));
      end else begin
        do_read("random_read", a);
      end
    end
    stall_en = 1'b0;
  endtask

  initial begin
    seed             = 69;
    errors           = 0;
    timeouts         = 0;
    stall_en         = 1'b0;
    clkrst_mem_rst_n = 1'b0;
    req_valid        = 1'b0;
    req_addr         = '0;
    req_we           = '0;
    req_wdata        = '0;
    for (int i = 0; i < 2048; i++) begin
      ref_mem[i] = preload_word(i);
    end
    repeat (5) @(posedge clkrst_mem_clk);
    #1;
    clkrst_mem_rst_n = 1'b1;

    read_and_count("cold_read", make_addr(3, 1, 2), 1);
    read_and_count("repeat_read", make_addr(3, 1, 6), 0);
    test_partial_write();
    test_write_miss();
    test_replacement();
    test_random_stalls();

    $display("errors: %0d mismatches, %0d timeouts", errors, timeouts);
    if (errors == 0 && timeouts == 0) begin
      $display("TEST PASSED");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: dl1c.f
dl1c_pkg.sv
dl1c_write_merge.sv
dl1c_line_ram.sv
dl1c_tag_store.sv
dl1c_ctrl.sv
dl1c_top.sv
tb_l2_model.sv
tb_dl1c.sv

// File: Bender.yml
package:
  name: dl1c

sources:
  - dl1c_pkg.sv
  - dl1c_write_merge.sv
  - dl1c_line_ram.sv
  - dl1c_tag_store.sv
  - dl1c_ctrl.sv
  - dl1c_top.sv
  - target: test
    files:
      - tb_l2_model.sv
      - tb_dl1c.sv
